//--- sa_top.f
design/sa_geom_pkg.sv
design/sa_ctrl_pkg.sv
design/sa_operand_if.sv
design/sa_operand_skew.sv
design/sa_pe_array.sv
design/sa_acc_fifo.sv
design/sa_psum_acc.sv
design/sa_drain_seq.sv
design/sa_top.sv
test/sa_psum_acc_asserts.sv
test/sa_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module sa_tb -f sa_top.f -o sa_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

./obj_dir/sa_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- test/sa_tb.sv
`timescale 1ns/1ps

module sa_tb;

    localparam int N         = sa_geom_pkg::SA_SIZE;
    localparam int DEPTH     = sa_ctrl_pkg::ACC_DEPTH;
    localparam int CLK_NS    = 40;
    localparam int NUM_TESTS = 6;
    localparam int IDLE_WAIT = 12;     // Deepest column result plus FIFO write, with margin
    localparam int DRAIN_MAX = 20;     // Cycles allowed for one drain

    logic                   clk;
    logic                   rst_n;
    logic                   wgt_load_i;
    sa_geom_pkg::act_vec_t  wgt_row_i;
    logic                   act_en_i;
    sa_geom_pkg::act_vec_t  act_vec_i;
    logic                   drain_i;
    logic                   drain_busy_o;
    logic                   out_valid_o;
    sa_geom_pkg::psum_vec_t psum_row_o;

    sa_geom_pkg::act_vec_t  wgt_m [N];    // Model weights, row k = k-th load
    sa_geom_pkg::act_vec_t  vecs [$];     // Vectors of the current pass
    sa_geom_pkg::psum_vec_t drained [$];  // Rows seen on the output
    int errors;
    int checks;

    sa_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wgt_load_i   (wgt_load_i),
        .wgt_row_i    (wgt_row_i),
        .act_en_i     (act_en_i),
        .act_vec_i    (act_vec_i),
        .drain_i      (drain_i),
        .drain_busy_o (drain_busy_o),
        .out_valid_o  (out_valid_o),
        .psum_row_o   (psum_row_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_NS);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;   // Inputs change just after the edge
    endtask

    task automatic check_psum_vec(input string name, input sa_geom_pkg::psum_vec_t exp_v,
                                  input sa_geom_pkg::psum_vec_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        checks++;
        if (act_n != exp_n) begin
            errors++;
            $display("Mismatch %s: expected %0d actual %0d", name, exp_n, act_n);
        end
    endtask

    // Column c sums a[r] * w[r][c] over the rows
    function automatic sa_geom_pkg::psum_vec_t matvec(input sa_geom_pkg::act_vec_t a);
        sa_geom_pkg::psum_vec_t p;
        for (int c = 0; c < N; c++) begin
            p[c] = '0;
            for (int r = 0; r < N; r++)
                p[c] += sa_geom_pkg::psum_t'(a[r]) * sa_geom_pkg::psum_t'(wgt_m[r][c]);
        end
        return p;
    endfunction

    function automatic sa_geom_pkg::act_vec_t pattern_vec(input int base);
        sa_geom_pkg::act_vec_t v;
        for (int e = 0; e < N; e++) v[e] = sa_geom_pkg::act_t'(base * 7 + e * 13 - 40);
        return v;
    endfunction

    task automatic load_weights();
        for (int k = 0; k < N; k++) begin
            wgt_load_i = 1'b1;
            wgt_row_i  = wgt_m[k];   // Shifts up, so first row ends on top
            next_cycle();
        end
        wgt_load_i = 1'b0;
    endtask

    task automatic send_vectors();
        foreach (vecs[n]) begin
            act_en_i  = 1'b1;
            act_vec_i = vecs[n];
            next_cycle();
        end
        act_en_i = 1'b0;
        repeat (IDLE_WAIT) next_cycle();   // Let the grid go idle
    endtask

    task automatic run_drain(input string name);
        bit seen_busy;
        bit done;
        seen_busy = 1'b0;
        done      = 1'b0;
        drained.delete();
        drain_i = 1'b1;
        next_cycle();
        drain_i = 1'b0;
        for (int i = 0; i < DRAIN_MAX && !done; i++) begin
            @(negedge clk);   // Outputs settled mid-cycle
            if (out_valid_o) drained.push_back(psum_row_o);
            if (drain_busy_o) seen_busy = 1'b1;
            else if (seen_busy) done = 1'b1;
        end
        if (!done) begin
            errors++;
            $display("%s: drain did not finish within %0d cycles", name, DRAIN_MAX);
        end
        next_cycle();
    endtask

    // Drain, then compare against slot sums n mod 4
    task automatic drain_and_check(input string name);
        sa_geom_pkg::psum_vec_t slots [DEPTH];
        sa_geom_pkg::psum_vec_t prod;
        int n_rows;
        int start;
        run_drain(name);
        for (int s = 0; s < DEPTH; s++) slots[s] = '0;
        foreach (vecs[n]) begin
            prod = matvec(vecs[n]);
            for (int c = 0; c < N; c++) slots[n % DEPTH][c] += prod[c];
        end
        n_rows = (vecs.size() < DEPTH) ? vecs.size() : DEPTH;
        start  = (vecs.size() < DEPTH) ? 0 : vecs.size() % DEPTH;   // Oldest slot after wrap
        check_count({name, " rows"}, n_rows, drained.size());
        for (int i = 0; i < n_rows && i < drained.size(); i++)
            check_psum_vec($sformatf("%s slot %0d", name, (start + i) % DEPTH),
                           slots[(start + i) % DEPTH], drained[i]);
    endtask

    task automatic test_reset();
        int active;
        active = 0;
        repeat (5) begin
            @(negedge clk);
            if (out_valid_o || drain_busy_o) active++;
        end
        next_cycle();
        check_count("reset idle outputs", 0, active);
        vecs.delete();
        drain_and_check("reset drain");
    endtask

    task automatic test_vectors(input string name, input int count, input int base);
        vecs.delete();
        for (int n = 0; n < count; n++) vecs.push_back(pattern_vec(base + n));
        send_vectors();
        drain_and_check(name);
    endtask

    task automatic set_ramp_weights(input int bias);
        for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++) wgt_m[r][c] = sa_geom_pkg::act_t'(r * 4 + c - bias);
        load_weights();
    endtask

    task automatic test_random();
        for (int r = 0; r < N; r++)
            for (int c = 0; c < N; c++) wgt_m[r][c] = sa_geom_pkg::act_t'($urandom);
        load_weights();
        vecs.delete();
        for (int n = 0; n < 10; n++) begin
            for (int e = 0; e < N; e++) act_vec_i[e] = sa_geom_pkg::act_t'($urandom);
            vecs.push_back(act_vec_i);
        end
        send_vectors();
        drain_and_check("random run");
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("%-24s %s", name, (errors == err_mark) ? "ok" : "FAILED");
    endtask

    initial begin
        int mark;
        void'($urandom(32'hc9eb_c3ae));
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        wgt_load_i = 1'b0;
        wgt_row_i  = '0;
        act_en_i   = 1'b0;
        act_vec_i  = '0;
        drain_i    = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();

        mark = errors;
        test_reset();
        report_test("after reset", mark);
        mark = errors;
        set_ramp_weights(5);
        test_vectors("one vector", 1, 0);
        report_test("one vector", mark);
        mark = errors;
        test_vectors("four vectors", 4, 3);
        report_test("four vectors", mark);
        mark = errors;
        test_vectors("six vectors", 6, -2);
        report_test("six vectors", mark);
        mark = errors;
        set_ramp_weights(9);    // New matrix, FIFOs start over with preloads
        test_vectors("weight reload", 3, 11);
        report_test("weight reload", mark);
        mark = errors;
        test_random();
        report_test("random run", mark);

        $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) $display("TEST RESULT: PASS");
        else $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- test/sa_psum_acc_asserts.sv
`timescale 1ns/1ps

module sa_psum_acc_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input sa_geom_pkg::col_mask_t psum_en_i,
    input sa_geom_pkg::col_mask_t wren_q_i,    // Registered FIFO writes
    input sa_geom_pkg::col_mask_t full_i,
    input sa_geom_pkg::col_mask_t rden_i,      // Merged FIFO reads
    input sa_geom_pkg::col_mask_t drain_rd_i,  // Reads from the sequencer
    input sa_geom_pkg::col_mask_t empty_i
);

    // Full FIFO only takes a write that recycles its head
    assert property (@(posedge clk) disable iff (!rst_n) (wren_q_i & full_i & ~rden_i) == '0)
        else $error("Write into full FIFO without read, wren %b full %b", wren_q_i, full_i);

    // Sequencer never pops an empty column
    assert property (@(posedge clk) disable iff (!rst_n) (drain_rd_i & empty_i) == '0)
        else $error("Drain read of empty FIFO, rden %b empty %b", drain_rd_i, empty_i);

    assert property (@(posedge clk) disable iff (!rst_n) wren_q_i == $past(psum_en_i))
        else $error("Registered write %b differs from last psum_en", wren_q_i);

endmodule

bind sa_psum_acc sa_psum_acc_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .psum_en_i  (psum_en_i),
    .wren_q_i   (wren_q),
    .full_i     (full),
    .rden_i     (rden),
    .drain_rd_i (rden_i),
    .empty_i    (empty_o)
);

//--- design/sa_top.sv
`timescale 1ns/1ps

module sa_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wgt_load_i,
    input  sa_geom_pkg::act_vec_t  wgt_row_i,
    input  logic                   act_en_i,
    input  sa_geom_pkg::act_vec_t  act_vec_i,
    input  logic                   drain_i,
    output logic                   drain_busy_o,
    output logic                   out_valid_o,
    output sa_geom_pkg::psum_vec_t psum_row_o
);

    sa_geom_pkg::col_mask_t psum_en;    // Grid column valids
    sa_geom_pkg::psum_vec_t psum_row;   // Grid column sums
    sa_geom_pkg::col_mask_t rden;       // Drain reads
    sa_geom_pkg::col_mask_t empty;

    sa_operand_if ops ();               // Skewed operands into the grid

    sa_operand_skew u_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .act_en_i   (act_en_i),
        .act_vec_i  (act_vec_i),
        .wgt_load_i (wgt_load_i),
        .wgt_row_i  (wgt_row_i),
        .ops        (ops.feeder)
    );

    sa_pe_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .ops        (ops.array),
        .psum_en_o  (psum_en),
        .psum_row_o (psum_row)
    );

    sa_psum_acc u_acc (
        .clk        (clk),
        .rst_n      (rst_n),
        .psum_en_i  (psum_en),
        .psum_row_i (psum_row),
        .rden_i     (rden),
        .empty_o    (empty),
        .psum_row_o (psum_row_o)
    );

    sa_drain_seq u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .drain_i      (drain_i),
        .empty_i      (empty),
        .rden_o       (rden),
        .out_valid_o  (out_valid_o),
        .drain_busy_o (drain_busy_o)
    );

endmodule

//--- design/sa_drain_seq.sv
`timescale 1ns/1ps

module sa_drain_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   drain_i,
    input  sa_geom_pkg::col_mask_t empty_i,
    output sa_geom_pkg::col_mask_t rden_o,
    output logic                   out_valid_o,
    output logic                   drain_busy_o
);

    sa_ctrl_pkg::drain_state_e state_q;
    sa_ctrl_pkg::drain_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            sa_ctrl_pkg::DRAIN_IDLE: if (drain_i) state_d = sa_ctrl_pkg::DRAIN_RUN;
            sa_ctrl_pkg::DRAIN_RUN:  if (&empty_i) state_d = sa_ctrl_pkg::DRAIN_IDLE;
            default:                 state_d = sa_ctrl_pkg::DRAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state_q <= sa_ctrl_pkg::DRAIN_IDLE;
        else        state_q <= state_d;
    end

    assign drain_busy_o = (state_q == sa_ctrl_pkg::DRAIN_RUN);

    // One head per non-empty column each cycle
    assign rden_o      = drain_busy_o ? ~empty_i : '0;
    assign out_valid_o = |rden_o;    // Same cycle as the read

endmodule

//--- design/sa_psum_acc.sv
`timescale 1ns/1ps

module sa_psum_acc (
    input  logic                    clk,
    input  logic                    rst_n,
    input  sa_geom_pkg::col_mask_t  psum_en_i,
    input  sa_geom_pkg::psum_vec_t  psum_row_i,
    input  sa_geom_pkg::col_mask_t  rden_i,
    output sa_geom_pkg::col_mask_t  empty_o,
    output sa_geom_pkg::psum_vec_t  psum_row_o
);

    sa_geom_pkg::col_mask_t wren_q;     // Write one cycle after psum_en
    sa_geom_pkg::psum_vec_t psum_q;     // Sum held for that write
    sa_geom_pkg::col_mask_t full;       // Accumulate instead of preload
    sa_geom_pkg::col_mask_t rden;
    sa_geom_pkg::psum_vec_t head;       // FIFO outputs
    sa_geom_pkg::psum_vec_t wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) wren_q <= '0;
        else        wren_q <= psum_en_i;
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < sa_geom_pkg::SA_SIZE; c++)
            if (psum_en_i[c]) psum_q[c] <= psum_row_i[c];
    end

    for (genvar c = 0; c < sa_geom_pkg::SA_SIZE; c++) begin : g_col
        // Full means slot n mod 4 already holds a sum, so add the head
        assign wdata[c] = (full[c] ? head[c] : '0) + psum_q[c];
        assign rden[c]  = (wren_q[c] & full[c]) | rden_i[c];

        sa_acc_fifo u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wren_i  (wren_q[c]),
            .rden_i  (rden[c]),
            .wdata_i (wdata[c]),
            .rdata_o (head[c]),
            .full_o  (full[c]),
            .empty_o (empty_o[c])
        );
    end

    assign psum_row_o = head;   // Drain sees the heads directly

endmodule

//--- design/sa_acc_fifo.sv
`timescale 1ns/1ps

module sa_acc_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wren_i,
    input  logic               rden_i,
    input  sa_geom_pkg::psum_t wdata_i,
    output sa_geom_pkg::psum_t rdata_o,
    output logic               full_o,
    output logic               empty_o
);

    sa_geom_pkg::psum_t    mem [sa_ctrl_pkg::ACC_DEPTH];   // Storage, no reset
    sa_ctrl_pkg::acc_ptr_t wr_ptr;
    sa_ctrl_pkg::acc_ptr_t rd_ptr;
    sa_ctrl_pkg::acc_cnt_t cnt;         // Occupancy
    logic                  do_wr;
    logic                  do_rd;

    assign full_o  = (cnt == sa_ctrl_pkg::acc_cnt_t'(sa_ctrl_pkg::ACC_DEPTH));
    assign empty_o = (cnt == '0);

    // Write when full only together with a read
    assign do_wr = wren_i && (!full_o || rden_i);
    assign do_rd = rden_i && !empty_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd) cnt <= cnt + 1'b1;
            else if (do_rd && !do_wr) cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wdata_i;
    end

    assign rdata_o = mem[rd_ptr];   // Show-ahead head

endmodule

//--- design/sa_pe_array.sv
`timescale 1ns/1ps

module sa_pe_array (
    input  logic                    clk,
    input  logic                    rst_n,
    sa_operand_if.array             ops,
    output sa_geom_pkg::col_mask_t  psum_en_o,
    output sa_geom_pkg::psum_vec_t  psum_row_o
);

    localparam int N = sa_geom_pkg::SA_SIZE;

    sa_geom_pkg::act_t  wgt_q  [N][N];   // Stationary weights
    sa_geom_pkg::act_t  act_q  [N][N];   // Activations moving right
    logic               en_q   [N][N];   // Valid moving with them
    sa_geom_pkg::psum_t psum_q [N][N];   // Sums moving down

    // Weight load shifts rows upward, new row enters at the bottom
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < N; r++)
                for (int c = 0; c < N; c++) wgt_q[r][c] <= '0;
        end else if (ops.wgt_load) begin
            for (int r = 0; r < N-1; r++)
                for (int c = 0; c < N; c++) wgt_q[r][c] <= wgt_q[r+1][c];
            for (int c = 0; c < N; c++) wgt_q[N-1][c] <= ops.wgt_row[c];
        end
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            sa_geom_pkg::act_t  a_in;    // From the west
            logic               en_in;
            sa_geom_pkg::psum_t s_in;    // From the north

            if (c == 0) begin : g_west_edge
                assign a_in  = ops.act_vec[r];
                assign en_in = ops.act_en[r];
            end else begin : g_west_cell
                assign a_in  = act_q[r][c-1];
                assign en_in = en_q[r][c-1];
            end

            if (r == 0) begin : g_north_edge
                assign s_in = '0;    // Column starts from zero
            end else begin : g_north_cell
                assign s_in = psum_q[r-1][c];
            end

            // MAC cell, bubbles carry zero
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    act_q[r][c]  <= '0;
                    en_q[r][c]   <= 1'b0;
                    psum_q[r][c] <= '0;
                end else begin
                    en_q[r][c] <= en_in;
                    if (en_in) act_q[r][c] <= a_in;   // Hold during bubbles
                    if (en_in) begin
                        psum_q[r][c] <= s_in + a_in * wgt_q[r][c];   // Signed MAC
                    end else begin
                        psum_q[r][c] <= '0;
                    end
                end
            end

            if (r == N-1) begin : g_bottom
                assign psum_row_o[c] = psum_q[r][c];   // Finished column sum
                assign psum_en_o[c]  = en_q[r][c];
            end
        end
    end

endmodule

//--- design/sa_operand_skew.sv
`timescale 1ns/1ps

module sa_operand_skew (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  act_en_i,
    input  sa_geom_pkg::act_vec_t act_vec_i,
    input  logic                  wgt_load_i,
    input  sa_geom_pkg::act_vec_t wgt_row_i,
    sa_operand_if.feeder          ops
);

    wire sa_geom_pkg::act_vec_t  skew_act;   // Tails of the delay lines
    wire sa_geom_pkg::col_mask_t skew_en;

    // Row r gets r+1 stages, so the grid sees a diagonal wavefront
    for (genvar r = 0; r < sa_geom_pkg::SA_SIZE; r++) begin : g_row
        sa_geom_pkg::act_t dat_q [r+1];   // Data stages, no reset
        logic [r:0]        en_q;          // Valid stages

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                en_q <= '0;
            end else begin
                en_q[0] <= act_en_i;
                for (int k = 1; k <= r; k++) en_q[k] <= en_q[k-1];
            end
        end

        always_ff @(posedge clk) begin
            dat_q[0] <= act_vec_i[r];   // Grid ignores data while en is low
            for (int k = 1; k <= r; k++) dat_q[k] <= dat_q[k-1];
        end

        assign skew_act[r] = dat_q[r];
        assign skew_en[r]  = en_q[r];
    end

    assign ops.act_vec  = skew_act;
    assign ops.act_en   = skew_en;
    assign ops.wgt_row  = wgt_row_i;    // Weights need no skew
    assign ops.wgt_load = wgt_load_i;

endmodule

//--- design/sa_operand_if.sv
`timescale 1ns/1ps

interface sa_operand_if;

    sa_geom_pkg::act_vec_t  act_vec;    // Skewed activations, one per row
    sa_geom_pkg::col_mask_t act_en;     // Per-row valid, skewed with the data
    sa_geom_pkg::act_vec_t  wgt_row;    // One weight per column
    logic                   wgt_load;   // Shift weights up by one row

    // Input side drives everything
    modport feeder (output act_vec, output act_en, output wgt_row, output wgt_load);

    // Grid only listens
    modport array (input act_vec, input act_en, input wgt_row, input wgt_load);

endinterface

//--- design/sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    // Accumulation FIFO sizing
    localparam int ACC_DEPTH = 4;   // Entries per column

    typedef logic [$clog2(ACC_DEPTH)-1:0] acc_ptr_t;   // Wraps at depth
    typedef logic [$clog2(ACC_DEPTH):0] acc_cnt_t;     // 0 .. ACC_DEPTH

    // Drain sequencer
    typedef enum logic {
        DRAIN_IDLE,   // Waiting for drain pulse
        DRAIN_RUN     // Emptying the FIFOs
    } drain_state_e;

endpackage

//--- design/sa_geom_pkg.sv
package sa_geom_pkg;

    // Grid geometry
    localparam int SA_SIZE = 4;    // Rows and columns
    localparam int ACT_W   = 8;    // Activation and weight width
    localparam int PSUM_W  = 32;   // Partial-sum width

    // One signed activation, also used for weights
    typedef logic signed [ACT_W-1:0] act_t;

    // One signed partial sum
    typedef logic signed [PSUM_W-1:0] psum_t;

    // Element c sits at index c, element 0 in the low bits
    typedef act_t [SA_SIZE-1:0] act_vec_t;     // 32 bits
    typedef psum_t [SA_SIZE-1:0] psum_vec_t;   // 128 bits

    // One bit per row or column
    typedef logic [SA_SIZE-1:0] col_mask_t;

endpackage
